//--- project.f
hdl/dz_pkg.sv
hdl/scan_tick.sv
hdl/scene_sequencer.sv
hdl/glyph_rom.sv
hdl/dz_show.sv
hdl/dz_game_top.sv
sim/dz_game_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dz_game testbench, result decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module dz_game_tb -o dz_game_sim \
    && ./obj_dir/dz_game_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; test -s sim.log || { echo "simulation did not run"; exit 1; }
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- sim/dz_game_tb.sv
`timescale 1ns/1ps

module dz_game_tb;

    logic                clk;
    logic                st;
    logic                start;
    logic                hit;
    logic                miss;
    dz_pkg::led_drive_t  disp;

    dz_pkg::game_state_e exp_state;
    logic [3:0]          exp_level;
    logic                exp_retry;
    dz_pkg::scene_e      exp_scene;
    logic                chk_en;      // panel is expected to show exp_scene
    logic                frame_done;
    logic [7:0]          acc_r;
    logic [7:0]          acc_g;
    logic [7:0]          row_q;
    int                  row_age;
    int                  errors;
    int                  pulses;
    int                  frames;
    int                  n_hits;

    dz_game_top i_dz_game_top (
        .clk   (clk),
        .st    (st),
        .start (start),
        .hit   (hit),
        .miss  (miss),
        .disp  (disp)
    );

    always #2 clk = ~clk;

    // colour rules of the panel
    function automatic logic red_copies(input dz_pkg::scene_e sc, input logic rt);
        if (sc == dz_pkg::SC_LVL6 || sc == dz_pkg::SC_LVL7 || sc == dz_pkg::SC_WIN)
            return 1'b1;
        return !rt && (int'(sc) <= 5);
    endfunction

    function automatic logic green_only(input dz_pkg::scene_e sc, input logic rt);
        return (sc == dz_pkg::SC_IDLE) || (rt && int'(sc) <= 5);
    endfunction

    function automatic logic red_face(input dz_pkg::scene_e sc);
        return (sc == dz_pkg::SC_LOSE) || (sc == dz_pkg::SC_OVER);
    endfunction

    // row select one step on, active low
    function automatic logic [7:0] next_row_sel(input logic [7:0] prev);
        logic [7:0] lit;
        lit = ~prev;
        return ~{lit[6:0], lit[7]};
    endfunction

    always @(posedge clk)
    begin
        if (!st)
        begin
            row_q   <= 8'hff;
            row_age <= 0;
        end
        else
        begin
            row_q   <= disp.row;
            row_age <= (disp.row != row_q) ? 1 : row_age + 1;
        end
    end

    a_reset_blank : assert property (@(posedge clk)
        (!st || disp.row == 8'hff) |-> (disp.colr == 8'h00 && disp.colg == 8'h00))
        else
        begin
            $display("Error: reset_blank expected 0000 actual %h%h",
                     $sampled(disp.colr), $sampled(disp.colg));
            errors = errors + 1;
        end

    a_reset_row : assert property (@(posedge clk) !st |-> disp.row == 8'hff)
        else
        begin
            $display("Error: reset_row expected ff actual %h", $sampled(disp.row));
            errors = errors + 1;
        end

    a_row_onehot : assert property (@(posedge clk) disable iff (!st)
        disp.row != 8'hff |-> $onehot(~disp.row))
        else
        begin
            $display("Error: row_onehot expected one low bit actual %b", $sampled(disp.row));
            errors = errors + 1;
        end

    a_row_period : assert property (@(posedge clk) disable iff (!st)
        (disp.row != row_q && row_q != 8'hff) |-> row_age == dz_pkg::SCAN_DIV)
        else
        begin
            $display("Error: row_period expected %0d actual %0d",
                     dz_pkg::SCAN_DIV, $sampled(row_age));
            errors = errors + 1;
        end

    a_row_next : assert property (@(posedge clk) disable iff (!st)
        (disp.row != row_q && row_q != 8'hff) |-> disp.row == next_row_sel(row_q))
        else
        begin
            $display("Error: row_next expected %b actual %b",
                     next_row_sel($sampled(row_q)), $sampled(disp.row));
            errors = errors + 1;
        end

    a_scene_req : assert property (@(posedge clk) disable iff (!st)
        chk_en |-> i_dz_game_top.req == {exp_scene, exp_retry})
        else
        begin
            $display("Error: scene_req expected %h actual %h",
                     {exp_scene, exp_retry}, $sampled(i_dz_game_top.req));
            errors = errors + 1;
        end

    a_yellow : assert property (@(posedge clk) disable iff (!st)
        (chk_en && red_copies(exp_scene, exp_retry)) |-> disp.colr == disp.colg)
        else
        begin
            $display("Error: yellow expected %h actual %h",
                     $sampled(disp.colg), $sampled(disp.colr));
            errors = errors + 1;
        end

    a_green_only : assert property (@(posedge clk) disable iff (!st)
        (chk_en && green_only(exp_scene, exp_retry)) |-> disp.colr == 8'h00)
        else
        begin
            $display("Error: green_only expected 00 actual %h", $sampled(disp.colr));
            errors = errors + 1;
        end

    a_red_only : assert property (@(posedge clk) disable iff (!st)
        (chk_en && red_face(exp_scene)) |-> disp.colg == 8'h00)
        else
        begin
            $display("Error: red_only expected 00 actual %h", $sampled(disp.colg));
            errors = errors + 1;
        end

    a_full_panel : assert property (@(posedge clk) disable iff (!st)
        (chk_en && exp_scene == dz_pkg::SC_LVL5) |-> disp.colg == 8'hff)
        else
        begin
            $display("Error: full_panel expected ff actual %h", $sampled(disp.colg));
            errors = errors + 1;
        end

    a_frame_red : assert property (@(posedge clk) disable iff (!st)
        (frame_done && red_face(exp_scene)) |-> acc_r != 8'h00)
        else
        begin
            $display("Error: frame_red expected nonzero actual %h", $sampled(acc_r));
            errors = errors + 1;
        end

    a_frame_green : assert property (@(posedge clk) disable iff (!st)
        (frame_done && exp_scene == dz_pkg::SC_IDLE) |-> acc_g != 8'h00)
        else
        begin
            $display("Error: frame_green expected nonzero actual %h", $sampled(acc_g));
            errors = errors + 1;
        end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("pulses %0d, frames %0d, errors %0d", pulses, frames, errors);
        $display("TESTS FAILED");
        $finish;
    endtask

    // waits for n row changes and ORs the colour words seen meanwhile
    task automatic wait_rows(input int n);
        int         seen;
        int         cyc;
        logic [7:0] last;
        seen  = 0;
        cyc   = 0;
        last  = disp.row;
        acc_r = 8'h00;
        acc_g = 8'h00;
        while (seen < n && cyc < n * dz_pkg::SCAN_DIV + 8)
        begin
            @(posedge clk);
            #1;
            cyc   = cyc + 1;
            acc_r = acc_r | disp.colr;
            acc_g = acc_g | disp.colg;
            if (disp.row != last)
            begin
                seen = seen + 1;
                last = disp.row;
            end
        end
        if (seen < n)
            abort_run("timeout: the panel stopped scanning rows");
    endtask

    task automatic scan_frame;
        wait_rows(dz_pkg::NUM_ROWS);
        frames     = frames + 1;
        frame_done = 1'b1;
        @(posedge clk);
        #1;
        frame_done = 1'b0;
    endtask

    task automatic press_button(input string btn);
        chk_en = 1'b0;
        start  = (btn == "start");
        hit    = (btn == "hit");
        miss   = (btn == "miss");
        @(posedge clk);
        #1;
        start  = 1'b0;
        hit    = 1'b0;
        miss   = 1'b0;
        pulses = pulses + 1;
        case (exp_state)
            dz_pkg::ST_IDLE, dz_pkg::ST_LOSE:
                if (btn == "start")
                begin
                    exp_state = dz_pkg::ST_PLAY;
                    exp_level = 4'd0;
                end
            dz_pkg::ST_PLAY:
                if (btn == "hit" && int'(exp_level) < dz_pkg::NUM_LEVELS - 1)
                    exp_level = exp_level + 4'd1;
                else if (btn == "hit")
                begin
                    exp_state = dz_pkg::ST_WIN;
                    exp_retry = 1'b0;
                end
                else if (btn == "miss")
                begin
                    exp_state = exp_retry ? dz_pkg::ST_OVER : dz_pkg::ST_LOSE;
                    exp_retry = 1'b1;
                end
            default:
                if (btn == "start")
                begin
                    exp_state = dz_pkg::ST_IDLE;
                    exp_retry = 1'b0;
                end
        endcase
        case (exp_state)
            dz_pkg::ST_PLAY: exp_scene = dz_pkg::scene_e'(exp_level);
            dz_pkg::ST_WIN:  exp_scene = dz_pkg::SC_WIN;
            dz_pkg::ST_LOSE: exp_scene = dz_pkg::SC_LOSE;
            dz_pkg::ST_OVER: exp_scene = dz_pkg::SC_OVER;
            default:         exp_scene = dz_pkg::SC_IDLE;
        endcase
        wait_rows(2);   // new scene is on the panel from here
        chk_en = 1'b1;
        scan_frame();
    endtask

    initial
    begin
        void'($urandom(40));
        clk        = 1'b0;
        st         = 1'b1;
        start      = 1'b0;
        hit        = 1'b0;
        miss       = 1'b0;
        chk_en     = 1'b0;
        frame_done = 1'b0;
        acc_r      = 8'h00;
        acc_g      = 8'h00;
        errors     = 0;
        pulses     = 0;
        frames     = 0;
        exp_state  = dz_pkg::ST_IDLE;
        exp_level  = 4'd0;
        exp_retry  = 1'b0;
        exp_scene  = dz_pkg::SC_IDLE;
        #1;
        st = 1'b0;   // falling edge starts the reset before the first clock
        repeat (5) @(posedge clk);
        #1;
        st     = 1'b1;
        chk_en = 1'b1;
        scan_frame();
        press_button("hit");   // not legal in idle
        press_button("start");
        repeat (dz_pkg::NUM_LEVELS) press_button("hit");
        press_button("start");
        n_hits = $urandom % dz_pkg::NUM_LEVELS;
        press_button("start");
        repeat (n_hits) press_button("hit");
        press_button("miss");
        press_button("start");   // second try, retry stays set
        repeat (5) press_button("hit");
        press_button("miss");
        press_button("start");
        $display("pulses %0d, frames %0d, errors %0d", pulses, frames, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- hdl/dz_game_top.sv
`timescale 1ns/1ps

module dz_game_top (
    input  logic               clk,
    input  logic               st,
    input  logic               start,
    input  logic               hit,
    input  logic               miss,
    output dz_pkg::led_drive_t disp
);

    logic               scan_en;
    dz_pkg::scene_req_t req;

    scan_tick i_scan_tick (
        .clk     (clk),
        .st      (st),
        .scan_en (scan_en)
    );

    scene_sequencer i_scene_sequencer (
        .clk   (clk),
        .st    (st),
        .start (start),
        .hit   (hit),
        .miss  (miss),
        .req   (req)
    );

    dz_show i_dz_show (
        .clk     (clk),
        .st      (st),
        .scan_en (scan_en),
        .req     (req),
        .disp    (disp)
    );

endmodule

//--- hdl/dz_show.sv
`timescale 1ns/1ps

module dz_show (
    input  logic               clk,
    input  logic               st,
    input  logic               scan_en,
    input  dz_pkg::scene_req_t req,
    output dz_pkg::led_drive_t disp
);

    logic [dz_pkg::ROW_W-1:0]    row_idx;
    logic [dz_pkg::ROW_W-1:0]    row_nxt;
    logic [7:0]                  green;
    logic [7:0]                  red;
    logic                        merge;     // red copies green, shows yellow

    assign row_nxt = (int'(row_idx) == dz_pkg::NUM_ROWS - 1) ? '0 : row_idx + 1'b1;

    // the tick that takes a request already draws with it
    glyph_rom i_glyph_rom (
        .scene   (req.scene),
        .row_idx (row_nxt),
        .green   (green),
        .red     (red)
    );

    always_comb
    begin
        case (req.scene)
            dz_pkg::SC_LVL0, dz_pkg::SC_LVL1, dz_pkg::SC_LVL2,
            dz_pkg::SC_LVL3, dz_pkg::SC_LVL4, dz_pkg::SC_LVL5:
                merge = !req.retry;   // green only on the second try
            dz_pkg::SC_LVL6, dz_pkg::SC_LVL7, dz_pkg::SC_WIN:
                merge = 1'b1;
            default:
                merge = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            row_idx     <= '1;   // first tick lands on row 0
            disp.row    <= '1;
            disp.colr   <= '0;
            disp.colg   <= '0;
        end
        else if (scan_en)
        begin
            row_idx   <= row_nxt;
            disp.row  <= ~(8'b1 << row_nxt);
            disp.colg <= green;
            disp.colr <= red | (merge ? green : 8'b0);
        end
    end

    a_row_onehot : assert property (@(posedge clk) disable iff (!st)
        scan_en |=> $onehot(~disp.row) [*dz_pkg::SCAN_DIV]);

endmodule

//--- hdl/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  dz_pkg::scene_e             scene,
    input  logic [dz_pkg::ROW_W-1:0]   row_idx,
    output logic [7:0]                 green,
    output logic [7:0]                 red
);

    always_comb
    begin
        green = '0;
        red   = '0;
        case (scene)
            dz_pkg::SC_LVL0:
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0001_1000;
                    3'd3, 3'd4: green = 8'b0011_1100;
                    default:    green = '0;
                endcase
            dz_pkg::SC_LVL1:
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1000;
                    3'd3, 3'd4: green = 8'b0111_1100;
                    default:    green = '0;
                endcase
            dz_pkg::SC_LVL2:
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1100;
                    3'd3, 3'd4: green = 8'b0111_1110;
                    default:    green = '0;
                endcase
            dz_pkg::SC_LVL3:
                case (row_idx)
                    3'd1, 3'd6:             green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: green = 8'b0111_1110;
                    default:                green = '0;
                endcase
            dz_pkg::SC_LVL4:
                case (row_idx)
                    3'd0, 3'd7: green = 8'b0011_1100;
                    3'd1, 3'd6: green = 8'b0111_1110;
                    default:    green = 8'b1111_1111;
                endcase
            dz_pkg::SC_LVL5: green = 8'b1111_1111;   // full panel
            dz_pkg::SC_LVL6:
                case (row_idx)
                    3'd0:    green = 8'b1100_0011;
                    3'd1:    green = 8'b1110_0011;
                    3'd2:    green = 8'b1111_0001;
                    3'd3:    green = 8'b1110_0011;
                    3'd4:    green = 8'b1100_0111;
                    3'd5:    green = 8'b1110_0111;
                    3'd6:    green = 8'b1111_0111;
                    default: green = 8'b1111_1011;
                endcase
            dz_pkg::SC_LVL7:
                case (row_idx)
                    3'd1:    green = 8'b0000_0001;
                    3'd2:    green = 8'b1000_0001;
                    3'd3:    green = 8'b1100_0011;
                    3'd4:    green = 8'b1000_0011;
                    3'd5:    green = 8'b1100_0111;
                    3'd6:    green = 8'b1110_0111;
                    3'd7:    green = 8'b1111_0011;
                    default: green = '0;
                endcase
            dz_pkg::SC_LOSE:
                case (row_idx)
                    3'd1:    red = 8'b0011_1000;
                    3'd2:    red = 8'b0100_0100;
                    3'd3:    red = 8'b0101_1010;
                    3'd4:    red = 8'b0100_1010;
                    3'd5:    red = 8'b0011_0010;
                    3'd6:    red = 8'b1100_0100;
                    3'd7:    red = 8'b0011_1000;
                    default: red = '0;
                endcase
            dz_pkg::SC_WIN:
                case (row_idx)
                    3'd2:    green = 8'b0110_0000;
                    3'd3:    green = 8'b1111_1100;
                    3'd4:    green = 8'b0011_1111;
                    3'd5:    green = 8'b0011_1110;
                    3'd6:    green = 8'b0001_1100;
                    default: green = '0;
                endcase
            dz_pkg::SC_IDLE:
                case (row_idx)
                    3'd2:       green = 8'b0001_1000;
                    3'd3:       green = 8'b0011_1100;
                    3'd4, 3'd5: green = 8'b0111_1110;
                    3'd6:       green = 8'b0010_0100;
                    default:    green = '0;
                endcase
            dz_pkg::SC_OVER:
                case (row_idx)
                    3'd0:    red = 8'b1110_0000;
                    3'd1:    red = 8'b0110_0000;
                    3'd2:    red = 8'b1110_0000;
                    3'd3:    red = 8'b0011_0000;
                    3'd4:    red = 8'b0011_0001;
                    3'd5:    red = 8'b0011_0011;
                    3'd6:    red = 8'b0011_1110;
                    default: red = 8'b0001_1100;
                endcase
            default:
            begin
                green = '0;
                red   = '0;
            end
        endcase
    end

endmodule

//--- hdl/scene_sequencer.sv
`timescale 1ns/1ps

module scene_sequencer (
    input  logic               clk,
    input  logic               st,
    input  logic               start,
    input  logic               hit,
    input  logic               miss,
    output dz_pkg::scene_req_t req
);

    dz_pkg::game_state_e state, state_n;
    logic [2:0]          level, level_n;
    logic                retry, retry_n;
    logic                hit_ok, miss_ok;
    dz_pkg::scene_req_t  req_n;

    // one pulse per cycle, start wins over hit, hit over miss
    assign hit_ok  = hit & ~start;
    assign miss_ok = miss & ~start & ~hit;

    always_comb
    begin
        state_n = state;
        level_n = level;
        retry_n = retry;
        case (state)
            dz_pkg::ST_IDLE:
                if (start)
                begin
                    state_n = dz_pkg::ST_PLAY;
                    level_n = '0;
                end
            dz_pkg::ST_PLAY:
                if (hit_ok)
                begin
                    if (int'(level) < dz_pkg::NUM_LEVELS - 1)
                        level_n = level + 1'b1;
                    else
                    begin
                        state_n = dz_pkg::ST_WIN;
                        retry_n = 1'b0;
                    end
                end
                else if (miss_ok)
                begin
                    if (!retry)
                    begin
                        state_n = dz_pkg::ST_LOSE;
                        retry_n = 1'b1;
                    end
                    else
                        state_n = dz_pkg::ST_OVER;   // second loss
                end
            dz_pkg::ST_LOSE:
                if (start)
                begin
                    state_n = dz_pkg::ST_PLAY;   // retry stays set
                    level_n = '0;
                end
            dz_pkg::ST_WIN, dz_pkg::ST_OVER:
                if (start)
                begin
                    state_n = dz_pkg::ST_IDLE;
                    retry_n = 1'b0;
                end
            default: state_n = dz_pkg::ST_IDLE;
        endcase
    end

    // scene follows the next state so req moves on the pulse edge
    always_comb
    begin
        req_n.retry = retry_n;
        case (state_n)
            dz_pkg::ST_PLAY: req_n.scene = dz_pkg::scene_e'({1'b0, level_n});
            dz_pkg::ST_WIN:  req_n.scene = dz_pkg::SC_WIN;
            dz_pkg::ST_LOSE: req_n.scene = dz_pkg::SC_LOSE;
            dz_pkg::ST_OVER: req_n.scene = dz_pkg::SC_OVER;
            default:         req_n.scene = dz_pkg::SC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            state     <= dz_pkg::ST_IDLE;
            level     <= '0;
            retry     <= 1'b0;
            req.scene <= dz_pkg::SC_IDLE;
            req.retry <= 1'b0;
        end
        else
        begin
            state <= state_n;
            level <= level_n;
            retry <= retry_n;
            req   <= req_n;
        end
    end

    // game over is only reached from a loss on the second try
    a_over_scene : assert property (@(posedge clk) disable iff (!st)
        (req.scene == dz_pkg::SC_OVER) |-> (state == dz_pkg::ST_OVER && req.retry));

endmodule

//--- hdl/scan_tick.sv
`timescale 1ns/1ps

module scan_tick (
    input  logic clk,
    input  logic st,
    output logic scan_en
);

    logic [$clog2(dz_pkg::SCAN_DIV)-1:0] cnt;

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            cnt     <= '0;
            scan_en <= 1'b0;
        end
        else
        begin
            scan_en <= (int'(cnt) == dz_pkg::SCAN_DIV - 1);
            if (int'(cnt) == dz_pkg::SCAN_DIV - 1)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end
    end

    a_single_pulse : assert property (@(posedge clk) disable iff (!st)
        scan_en |=> !scan_en);

endmodule

//--- hdl/dz_pkg.sv
package dz_pkg;

    localparam int NUM_ROWS   = 8;
    localparam int ROW_W      = 3;
    localparam int SCAN_DIV   = 4;   // clk cycles per row
    localparam int NUM_LEVELS = 8;

    // picture numbers as used by the glyph table
    typedef enum logic [3:0] {
        SC_LVL0 = 4'd0,
        SC_LVL1 = 4'd1,
        SC_LVL2 = 4'd2,
        SC_LVL3 = 4'd3,
        SC_LVL4 = 4'd4,
        SC_LVL5 = 4'd5,
        SC_LVL6 = 4'd6,
        SC_LVL7 = 4'd7,
        SC_LOSE = 4'd8,   // red face
        SC_WIN  = 4'd9,   // trophy
        SC_IDLE = 4'd10,
        SC_OVER = 4'd11
    } scene_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PLAY,
        ST_WIN,
        ST_LOSE,
        ST_OVER
    } game_state_e;

    typedef struct packed {
        scene_e scene;
        logic   retry;   // set after the first loss
    } scene_req_t;

    // panel pins, row select is active low
    typedef struct packed {
        logic [7:0] row;
        logic [7:0] colr;
        logic [7:0] colg;
    } led_drive_t;

endpackage
